// File: vid_regs_pkg.sv
// CPU register map, memory region enum and register reset values
`default_nettype none

package vid_regs_pkg;

	localparam int CPU_ADDR_W = 14; // byte address of the CPU slave port

	// selected by byte address bits 13:12
	typedef enum logic [1:0] {
		REGION_REGS    = 2'd0,
		REGION_PALETTE = 2'd1,
		REGION_TILEMAP = 2'd2,
		REGION_TILEMEM = 2'd3
	} cpu_region_e;

	// word indices, address bits 5:2
	localparam logic [3:0] REG_FB_ADDR  = 4'd0;
	localparam logic [3:0] REG_FB_PITCH = 4'd1;
	localparam logic [3:0] REG_LAYER_EN = 4'd2;
	localparam logic [3:0] REG_TILE_OFF = 4'd3; // x in bits 6:0, y in bits 22:16

	localparam logic [23:0] FB_ADDR_RESET = 24'h7E0000; // top of external memory
	localparam logic [15:0] PITCH_RESET   = 16'd32;     // bytes, one packed line

endpackage

`default_nettype wire

// File: vid_geom_pkg.sv
// screen, tile, tilemap and palette geometry and pixel widths
`default_nettype none

package vid_geom_pkg;

	localparam int LINE_PIXELS = 64;
	localparam int FRAME_LINES = 16;
	localparam int X_W = 6; // pixel column
	localparam int Y_W = 4; // line number

	localparam int PIX_W          = 4; // bits per palette index
	localparam int PIX_PER_WORD   = 8;
	localparam int WORDS_PER_LINE = 8;

	localparam int TILE_SIZE     = 8;
	localparam int MAP_COLS      = 16;
	localparam int MAP_ROWS      = 8;
	localparam int MAP_WORDS     = MAP_COLS * MAP_ROWS / 2; // two 16-bit entries per word
	localparam int TILE_COUNT    = 64;
	localparam int TILEMEM_WORDS = TILE_COUNT * TILE_SIZE;  // one word per tile row

	// scroll plane is 128 x 64 pixels
	localparam int OFF_W = $clog2(MAP_COLS * TILE_SIZE);

	// entries 0-15 framebuffer, 16-31 tile layer
	localparam int PAL_ENTRIES = 32;
	localparam int COLOR_W     = 24;

	localparam int LB_ADDR_W = Y_W + X_W; // {line, x}

endpackage

`default_nettype wire

// File: vid_cpu_regs.sv
// CPU address decode, control registers, memory write strobes and read-data mux
`timescale 1ns/1ns
`default_nettype none

module vid_cpu_regs (
	input  wire                                clk,
	input  wire                                reset,
	input  wire [vid_regs_pkg::CPU_ADDR_W-1:0] addr,
	input  wire [31:0]                         din,
	input  wire [3:0]                          wstrb,
	input  wire                                ren,
	input  wire [31:0]                         pal_rdata,
	input  wire [31:0]                         map_rdata,
	input  wire [31:0]                         tile_rdata,
	output logic [31:0]                        dout,
	output logic                               ready,
	output logic [23:0]                        fb_addr,
	output logic [15:0]                        pitch,
	output logic [1:0]                         layer_en,
	output logic [vid_geom_pkg::OFF_W-1:0]     tile_xoff,
	output logic [vid_geom_pkg::OFF_W-1:0]     tile_yoff,
	output logic                               pal_we,
	output logic                               map_we,
	output logic                               tile_we,
	output logic [8:0]                         mem_index,
	output logic [31:0]                        mem_wdata
);
	import vid_regs_pkg::*;

	cpu_region_e region;
	cpu_region_e rd_region; // region of the last read
	logic        wr;
	logic [3:0]  reg_sel;
	logic [31:0] reg_rdata;

	assign region    = cpu_region_e'(addr[CPU_ADDR_W-1:CPU_ADDR_W-2]);
	assign reg_sel   = addr[5:2];
	assign wr        = &wstrb; // partial writes are ignored
	assign mem_index = addr[10:2];
	assign mem_wdata = din;

	// one strobe per memory region
	assign pal_we  = wr && (region == REGION_PALETTE);
	assign map_we  = wr && (region == REGION_TILEMAP);
	assign tile_we = wr && (region == REGION_TILEMEM);

	always_ff @(posedge clk) begin
		if (reset) begin
			ready     <= 1'b0;
			rd_region <= REGION_REGS;
			fb_addr   <= FB_ADDR_RESET;
			pitch     <= PITCH_RESET;
			layer_en  <= 2'b00;
			tile_xoff <= '0;
			tile_yoff <= '0;
		end else begin
			ready <= (|wstrb) || ren;
			if (ren)
				rd_region <= region;
			if (wr && (region == REGION_REGS)) begin
				case (reg_sel)
					REG_FB_ADDR:  fb_addr  <= din[23:0];
					REG_FB_PITCH: pitch    <= din[15:0];
					REG_LAYER_EN: layer_en <= din[1:0];
					REG_TILE_OFF: begin
						tile_xoff <= din[6:0];
						tile_yoff <= din[22:16];
					end
					default: ;
				endcase
			end
		end
	end

	// register contents captured at access time, same latency as the memories
	always_ff @(posedge clk) begin
		case (reg_sel)
			REG_FB_ADDR:  reg_rdata <= {8'h00, fb_addr};
			REG_FB_PITCH: reg_rdata <= {16'h0000, pitch};
			REG_LAYER_EN: reg_rdata <= {30'd0, layer_en};
			REG_TILE_OFF: reg_rdata <= {9'd0, tile_yoff, 9'd0, tile_xoff};
			default:      reg_rdata <= 32'h0;
		endcase
	end

	always_comb begin
		case (rd_region)
			REGION_PALETTE: dout = pal_rdata;
			REGION_TILEMAP: dout = map_rdata;
			REGION_TILEMEM: dout = tile_rdata;
			default:        dout = reg_rdata;
		endcase
	end

endmodule

`default_nettype wire

// File: vid_fb_fetch.sv
// per-line framebuffer fetch from external memory into an eight-word queue
`timescale 1ns/1ns
`default_nettype none

module vid_fb_fetch (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          line_start,
	input  wire [vid_geom_pkg::Y_W-1:0]  line_no,
	input  wire [23:0]                   fb_addr,
	input  wire [15:0]                   pitch,
	input  wire                          fb_word_take,
	output logic                         fb_word_avail,
	output logic [31:0]                  fb_word,
	output logic                         mem_read,
	output logic [23:0]                  mem_addr,
	input  wire                          mem_rvalid,
	input  wire [31:0]                   mem_rdata
);
	import vid_geom_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_DATA
	} fetch_state_e;

	fetch_state_e state;

	logic [31:0] queue [WORDS_PER_LINE];
	logic [$clog2(WORDS_PER_LINE)-1:0] wr_ptr;
	logic [$clog2(WORDS_PER_LINE)-1:0] rd_ptr;
	logic [3:0]  count;   // words in the queue
	logic [3:0]  fetched; // words fetched for this line
	logic [23:0] next_addr;
	logic [23:0] line_base;
	logic        push;
	logic        pop;

	assign line_base = fb_addr + pitch * line_no; // evaluated at 24 bits

	assign push = (state == WAIT_DATA) && mem_rvalid;
	assign pop  = fb_word_take && (count != 4'd0);

	assign fb_word_avail = count != 4'd0;
	assign fb_word       = queue[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			mem_read <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= 4'd0;
			fetched  <= 4'd0;
		end else begin
			mem_read <= 1'b0;
			if (line_start) begin
				// drop whatever is left and restart at the new base
				state   <= REQUEST;
				wr_ptr  <= '0;
				rd_ptr  <= '0;
				count   <= 4'd0;
				fetched <= 4'd0;
			end else begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + 4'(push) - 4'(pop);
				case (state)
					REQUEST: begin
						mem_read <= 1'b1; // single-cycle strobe
						state    <= WAIT_DATA;
					end
					WAIT_DATA: begin
						if (mem_rvalid) begin
							fetched <= fetched + 4'd1;
							if (fetched == 4'(WORDS_PER_LINE - 1))
								state <= IDLE; // line complete
							else
								state <= REQUEST;
						end
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start) begin
			next_addr <= line_base;
		end else if (state == REQUEST) begin
			mem_addr  <= next_addr;
			next_addr <= next_addr + 24'd4;
		end
		if (push)
			queue[wr_ptr] <= mem_rdata;
	end

endmodule

`default_nettype wire

// File: vid_line_sequencer.sv
// frame and line FSM, line-buffer room check and pixel issue
`timescale 1ns/1ns
`default_nettype none

module vid_line_sequencer (
	input  wire                            clk,
	input  wire                            reset,
	input  wire [vid_geom_pkg::Y_W-1:0]    scan_line,
	input  wire                            next_field,
	input  wire                            fb_word_avail,
	input  wire [31:0]                     fb_word,
	output logic                           line_start,
	output logic [vid_geom_pkg::Y_W-1:0]   line_no,
	output logic                           fb_word_take,
	output logic                           px_valid,
	output logic [vid_geom_pkg::X_W-1:0]   px_x,
	output logic [vid_geom_pkg::Y_W-1:0]   px_line,
	output logic [vid_geom_pkg::PIX_W-1:0] px_fb_index
);
	import vid_geom_pkg::*;

	typedef enum logic [1:0] {
		FRAME_DONE,
		WAIT_ROOM,
		START,
		RENDER
	} seq_state_e;

	seq_state_e     state;
	logic [Y_W-1:0] line_cnt;
	logic [X_W-1:0] x;
	logic           issue;

	// stall only while the queue is empty
	assign issue = (state == RENDER) && fb_word_avail;

	assign line_start   = state == START;
	assign line_no      = line_cnt;
	assign fb_word_take = issue && (x[2:0] == 3'(PIX_PER_WORD - 1)); // last nibble

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= FRAME_DONE;
			line_cnt <= '0;
			x        <= '0;
			px_valid <= 1'b0;
		end else begin
			px_valid <= issue;
			case (state)
				FRAME_DONE: begin
					if (next_field) begin
						line_cnt <= '0;
						state    <= WAIT_ROOM;
					end
				end
				WAIT_ROOM: begin
					// scanout must be on the other half of the buffer
					if (line_cnt[0] != scan_line[0])
						state <= START;
				end
				START: begin
					x     <= '0;
					state <= RENDER;
				end
				RENDER: begin
					if (fb_word_avail) begin
						x <= x + 1'b1;
						if (x == X_W'(LINE_PIXELS - 1)) begin
							line_cnt <= line_cnt + 1'b1;
							if (line_cnt == Y_W'(FRAME_LINES - 1))
								state <= FRAME_DONE;
							else
								state <= WAIT_ROOM;
						end
					end
				end
				default: state <= FRAME_DONE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			px_x        <= x;
			px_line     <= line_cnt;
			px_fb_index <= fb_word[x[2:0]*PIX_W +: PIX_W]; // low nibble first
		end
	end

endmodule

`default_nettype wire

// File: vid_tile_stage.sv
// tilemap and tile memories, scroll arithmetic and tile pixel lookup
`timescale 1ns/1ns
`default_nettype none

module vid_tile_stage (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            map_we,
	input  wire                            tile_we,
	input  wire [8:0]                      mem_index,
	input  wire [31:0]                     mem_wdata,
	output logic [31:0]                    map_rdata,
	output logic [31:0]                    tile_rdata,
	input  wire [vid_geom_pkg::OFF_W-1:0]  tile_xoff,
	input  wire [vid_geom_pkg::OFF_W-1:0]  tile_yoff,
	input  wire                            px_valid,
	input  wire [vid_geom_pkg::X_W-1:0]    px_x,
	input  wire [vid_geom_pkg::Y_W-1:0]    px_line,
	input  wire [vid_geom_pkg::PIX_W-1:0]  px_fb_index,
	output logic                           tile_valid,
	output logic [vid_geom_pkg::X_W-1:0]   tile_x,
	output logic [vid_geom_pkg::Y_W-1:0]   tile_line,
	output logic [vid_geom_pkg::PIX_W-1:0] tile_fb_index,
	output logic [vid_geom_pkg::PIX_W-1:0] tile_index
);
	import vid_geom_pkg::*;

	logic [31:0] map_mem  [MAP_WORDS];
	logic [31:0] tile_mem [TILEMEM_WORDS];

	logic [OFF_W-1:0] sx;
	logic [OFF_W-1:0] sy;
	logic [15:0]      map_entry;

	// stage 1
	logic             valid1;
	logic [X_W-1:0]   x1;
	logic [Y_W-1:0]   line1;
	logic [PIX_W-1:0] fb1;
	logic [31:0]      map_word;
	logic             half1;
	logic [2:0]       row1;
	logic [2:0]       col1;

	// stage 2
	logic [31:0] row_word;
	logic [2:0]  col2;

	assign sx = OFF_W'(px_x) + tile_xoff;    // wraps at 128
	assign sy = OFF_W'(px_line) + tile_yoff; // only bits 5:0 used, wraps at 64

	assign map_entry  = half1 ? map_word[31:16] : map_word[15:0];
	assign tile_index = row_word[col2*PIX_W +: PIX_W];

	// CPU side of both memories
	always_ff @(posedge clk) begin
		if (map_we)
			map_mem[mem_index[$clog2(MAP_WORDS)-1:0]] <= mem_wdata;
		if (tile_we)
			tile_mem[mem_index] <= mem_wdata;
		map_rdata  <= map_mem[mem_index[$clog2(MAP_WORDS)-1:0]];
		tile_rdata <= tile_mem[mem_index];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid1     <= 1'b0;
			tile_valid <= 1'b0;
		end else begin
			valid1     <= px_valid;
			tile_valid <= valid1;
		end
	end

	always_ff @(posedge clk) begin
		// tilemap row sy[5:3], column pair sx[6:4], entry select sx[3]
		x1       <= px_x;
		line1    <= px_line;
		fb1      <= px_fb_index;
		map_word <= map_mem[{sy[5:3], sx[6:4]}];
		half1    <= sx[3];
		row1     <= sy[2:0];
		col1     <= sx[2:0];

		tile_x        <= x1;
		tile_line     <= line1;
		tile_fb_index <= fb1;
		row_word      <= tile_mem[{map_entry[$clog2(TILE_COUNT)-1:0], row1}];
		col2          <= col1;
	end

endmodule

`default_nettype wire

// File: vid_palette_stage.sv
// palette memory, two-layer lookup, transparency and layer composition
`timescale 1ns/1ns
`default_nettype none

module vid_palette_stage (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              pal_we,
	input  wire [8:0]                        mem_index,
	input  wire [31:0]                       mem_wdata,
	output logic [31:0]                      pal_rdata,
	input  wire [1:0]                        layer_en,
	input  wire                              tile_valid,
	input  wire [vid_geom_pkg::X_W-1:0]      tile_x,
	input  wire [vid_geom_pkg::Y_W-1:0]      tile_line,
	input  wire [vid_geom_pkg::PIX_W-1:0]    tile_fb_index,
	input  wire [vid_geom_pkg::PIX_W-1:0]    tile_index,
	output logic                             vid_wen,
	output logic [vid_geom_pkg::LB_ADDR_W-1:0] vid_addr,
	output logic [vid_geom_pkg::COLOR_W-1:0] vid_data
);
	import vid_geom_pkg::*;

	localparam int PAL_IDX_W = $clog2(PAL_ENTRIES);

	logic [COLOR_W-1:0]   pal_mem [PAL_ENTRIES];
	logic [COLOR_W-1:0]   fb_color;
	logic [COLOR_W-1:0]   tl_color;
	logic                 fb_on;
	logic                 tl_on;
	logic                 valid3;
	logic [LB_ADDR_W-1:0] addr3;

	always_ff @(posedge clk) begin
		if (pal_we)
			pal_mem[mem_index[PAL_IDX_W-1:0]] <= mem_wdata[COLOR_W-1:0];
		pal_rdata <= 32'(pal_mem[mem_index[PAL_IDX_W-1:0]]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid3  <= 1'b0;
			vid_wen <= 1'b0;
		end else begin
			valid3  <= tile_valid;
			vid_wen <= valid3;
		end
	end

	always_ff @(posedge clk) begin
		// both lookups in parallel, tile layer in the upper half
		fb_color <= pal_mem[{1'b0, tile_fb_index}];
		tl_color <= pal_mem[{1'b1, tile_index}];
		fb_on    <= layer_en[0] && (tile_fb_index != '0); // index 0 is transparent
		tl_on    <= layer_en[1] && (tile_index != '0);
		addr3    <= {tile_line, tile_x};

		vid_addr <= addr3;
		if (tl_on)
			vid_data <= tl_color; // tile wins
		else if (fb_on)
			vid_data <= fb_color;
		else
			vid_data <= '0;
	end

endmodule

`default_nettype wire

// File: vid_linerenderer.sv
// line renderer top: CPU port, framebuffer fetch and pixel pipeline
`timescale 1ns/1ns
`default_nettype none

module vid_linerenderer (
	input  wire                                clk,
	input  wire                                reset,
	input  wire [vid_regs_pkg::CPU_ADDR_W-1:0] addr,
	input  wire [31:0]                         din,
	input  wire [3:0]                          wstrb,
	input  wire                                ren,
	output wire [31:0]                         dout,
	output wire                                ready,
	output wire                                mem_read,
	output wire [23:0]                         mem_addr,
	input  wire                                mem_rvalid,
	input  wire [31:0]                         mem_rdata,
	output wire                                vid_wen,
	output wire [vid_geom_pkg::LB_ADDR_W-1:0]  vid_addr,
	output wire [vid_geom_pkg::COLOR_W-1:0]    vid_data,
	input  wire [vid_geom_pkg::Y_W-1:0]        scan_line,
	input  wire                                next_field
);
	import vid_geom_pkg::*;

	wire [31:0]      pal_rdata;
	wire [31:0]      map_rdata;
	wire [31:0]      tile_rdata;
	wire [23:0]      fb_addr;
	wire [15:0]      pitch;
	wire [1:0]       layer_en;
	wire [OFF_W-1:0] tile_xoff;
	wire [OFF_W-1:0] tile_yoff;
	wire             pal_we;
	wire             map_we;
	wire             tile_we;
	wire [8:0]       mem_index;
	wire [31:0]      mem_wdata;

	wire             line_start;
	wire [Y_W-1:0]   line_no;
	wire             fb_word_avail;
	wire [31:0]      fb_word;
	wire             fb_word_take;

	wire             px_valid;
	wire [X_W-1:0]   px_x;
	wire [Y_W-1:0]   px_line;
	wire [PIX_W-1:0] px_fb_index;

	wire             tile_valid;
	wire [X_W-1:0]   tile_x;
	wire [Y_W-1:0]   tile_line;
	wire [PIX_W-1:0] tile_fb_index;
	wire [PIX_W-1:0] tile_index;

	vid_cpu_regs u_cpu_regs (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.din        (din),
		.wstrb      (wstrb),
		.ren        (ren),
		.pal_rdata  (pal_rdata),
		.map_rdata  (map_rdata),
		.tile_rdata (tile_rdata),
		.dout       (dout),
		.ready      (ready),
		.fb_addr    (fb_addr),
		.pitch      (pitch),
		.layer_en   (layer_en),
		.tile_xoff  (tile_xoff),
		.tile_yoff  (tile_yoff),
		.pal_we     (pal_we),
		.map_we     (map_we),
		.tile_we    (tile_we),
		.mem_index  (mem_index),
		.mem_wdata  (mem_wdata)
	);

	vid_fb_fetch u_fb_fetch (
		.clk           (clk),
		.reset         (reset),
		.line_start    (line_start),
		.line_no       (line_no),
		.fb_addr       (fb_addr),
		.pitch         (pitch),
		.fb_word_take  (fb_word_take),
		.fb_word_avail (fb_word_avail),
		.fb_word       (fb_word),
		.mem_read      (mem_read),
		.mem_addr      (mem_addr),
		.mem_rvalid    (mem_rvalid),
		.mem_rdata     (mem_rdata)
	);

	vid_line_sequencer u_sequencer (
		.clk           (clk),
		.reset         (reset),
		.scan_line     (scan_line),
		.next_field    (next_field),
		.fb_word_avail (fb_word_avail),
		.fb_word       (fb_word),
		.line_start    (line_start),
		.line_no       (line_no),
		.fb_word_take  (fb_word_take),
		.px_valid      (px_valid),
		.px_x          (px_x),
		.px_line       (px_line),
		.px_fb_index   (px_fb_index)
	);

	vid_tile_stage u_tile_stage (
		.clk           (clk),
		.reset         (reset),
		.map_we        (map_we),
		.tile_we       (tile_we),
		.mem_index     (mem_index),
		.mem_wdata     (mem_wdata),
		.map_rdata     (map_rdata),
		.tile_rdata    (tile_rdata),
		.tile_xoff     (tile_xoff),
		.tile_yoff     (tile_yoff),
		.px_valid      (px_valid),
		.px_x          (px_x),
		.px_line       (px_line),
		.px_fb_index   (px_fb_index),
		.tile_valid    (tile_valid),
		.tile_x        (tile_x),
		.tile_line     (tile_line),
		.tile_fb_index (tile_fb_index),
		.tile_index    (tile_index)
	);

	vid_palette_stage u_palette_stage (
		.clk           (clk),
		.reset         (reset),
		.pal_we        (pal_we),
		.mem_index     (mem_index),
		.mem_wdata     (mem_wdata),
		.pal_rdata     (pal_rdata),
		.layer_en      (layer_en),
		.tile_valid    (tile_valid),
		.tile_x        (tile_x),
		.tile_line     (tile_line),
		.tile_fb_index (tile_fb_index),
		.tile_index    (tile_index),
		.vid_wen       (vid_wen),
		.vid_addr      (vid_addr),
		.vid_data      (vid_data)
	);

endmodule

`default_nettype wire

// File: tb_vid_mem_model.sv
// external memory model with random read latency and address-derived data
`timescale 1ns/1ns
`default_nettype none

module tb_vid_mem_model (
	input  wire         clk,
	input  wire         reset,
	input  wire         mem_read,
	input  wire  [23:0] mem_addr,
	output logic        mem_rvalid,
	output logic [31:0] mem_rdata
);
	localparam int MAX_LATENCY = 6;

	integer      seed;
	logic        pending;  // one request in flight
	logic [23:0] req_addr;
	int          wait_cnt;

	initial begin
		seed       = 32'hc9627f20;
		pending    = 1'b0;
		wait_cnt   = 0;
		req_addr   = '0;
		mem_rvalid = 1'b0;
		mem_rdata  = '0;
	end

	always @(posedge clk) begin
		mem_rvalid <= 1'b0;
		if (reset) begin
			pending <= 1'b0;
		end else begin
			if (pending) begin
				if (wait_cnt == 0) begin
					mem_rvalid <= 1'b1;
					mem_rdata  <= {8'h00, req_addr} * 32'h9E3779B1; // address hash
					pending    <= 1'b0;
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
			if (mem_read) begin
				pending  <= 1'b1;
				req_addr <= mem_addr;
				// latency 1..6 cycles
				wait_cnt <= $unsigned($random(seed)) % MAX_LATENCY;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_vid_linerenderer.sv
// testbench clock, reset, CPU stimulus, reference model, pixel checks, report and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_vid_linerenderer;
	import vid_geom_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 10;
	localparam int FRAMES       = 4;
	localparam int CPU_CYCLES   = 6000; // register and memory tests
	localparam int FRAME_CYCLES = 5000; // upper bound for one rendered frame
	localparam int RUN_LIMIT_NS = (CPU_CYCLES + FRAMES * FRAME_CYCLES) * CLK_PERIOD;
	localparam int FRAME_PIXELS = LINE_PIXELS * FRAME_LINES;

	localparam logic [13:0] FB_ADDR_REG = 14'h0000;
	localparam logic [13:0] PITCH_REG   = 14'h0004;
	localparam logic [13:0] LAYER_REG   = 14'h0008;
	localparam logic [13:0] OFF_REG     = 14'h000C;
	localparam logic [13:0] PAL_BASE    = 14'h1000;
	localparam logic [13:0] MAP_BASE    = 14'h2000;
	localparam logic [13:0] TILE_BASE   = 14'h3000;

	logic                 clk;
	logic                 reset;
	logic [13:0]          addr;
	logic [31:0]          din;
	logic [3:0]           wstrb;
	logic                 ren;
	wire  [31:0]          dout;
	wire                  ready;
	wire                  mem_read;
	wire  [23:0]          mem_addr;
	wire                  mem_rvalid;
	wire  [31:0]          mem_rdata;
	wire                  vid_wen;
	wire  [LB_ADDR_W-1:0] vid_addr;
	wire  [COLOR_W-1:0]   vid_data;
	logic [Y_W-1:0]       scan_line = Y_W'(FRAME_LINES - 1); // last line of the previous field
	logic                 next_field;

	// reference copies of everything written to the DUT
	logic [23:0]        ref_fb_addr = 24'h7E0000;
	logic [15:0]        ref_pitch = 16'd32;
	logic [1:0]         ref_layer = 2'b00;
	logic [6:0]         ref_xoff = '0;
	logic [6:0]         ref_yoff = '0;
	logic [COLOR_W-1:0] pal_ref [PAL_ENTRIES];
	logic [31:0]        map_ref [MAP_WORDS];
	logic [31:0]        tile_ref [TILEMEM_WORDS];

	logic [COLOR_W-1:0] saved [1 << LB_ADDR_W]; // one earlier frame
	logic               written [1 << LB_ADDR_W];
	int                 line_pixels [FRAME_LINES];
	int                 pix_count = 0;
	int                 frames_done = 0;
	logic               save_frame = 1'b0;
	logic               match_saved = 1'b0;
	logic               acc_q = 1'b0;
	logic               read_open = 1'b0; // external read not yet answered
	int                 errors = 0;
	int                 checks = 0;
	int                 tests_run = 0;

	vid_linerenderer u_vid_linerenderer (
		.clk        (clk),
		.reset      (reset),
		.addr       (addr),
		.din        (din),
		.wstrb      (wstrb),
		.ren        (ren),
		.dout       (dout),
		.ready      (ready),
		.mem_read   (mem_read),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.vid_wen    (vid_wen),
		.vid_addr   (vid_addr),
		.vid_data   (vid_data),
		.scan_line  (scan_line),
		.next_field (next_field)
	);

	tb_vid_mem_model u_mem_model (
		.clk        (clk),
		.reset      (reset),
		.mem_read   (mem_read),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] model_word(input logic [23:0] byte_addr);
		return {8'h00, byte_addr} * 32'h9E3779B1;
	endfunction

	// color of one screen pixel from the layer rules and the reference copies
	function automatic logic [COLOR_W-1:0] expected_color(input logic [Y_W-1:0] line,
			input logic [X_W-1:0] x);
		logic [23:0] byte_addr;
		logic [31:0] fb_data;
		logic [3:0]  fb_idx;
		logic [6:0]  sx;
		logic [5:0]  sy;
		int          map_pos;
		logic [31:0] map_data;
		logic [15:0] entry;
		logic [31:0] row;
		logic [3:0]  tl_idx;
		byte_addr = ref_fb_addr + 24'(line) * 24'(ref_pitch) + 24'(x / PIX_PER_WORD) * 24'd4;
		fb_data   = model_word(byte_addr);
		fb_idx    = 4'(fb_data >> (PIX_W * (x % PIX_PER_WORD)));
		sx        = 7'(x + ref_xoff); // 128 pixels wide
		sy        = 6'(line + ref_yoff); // 64 lines high
		map_pos   = (sy / TILE_SIZE) * MAP_COLS + sx / TILE_SIZE;
		map_data  = map_ref[map_pos / 2];
		entry     = (map_pos % 2 == 1) ? map_data[31:16] : map_data[15:0];
		row       = tile_ref[(entry % TILE_COUNT) * TILE_SIZE + sy % TILE_SIZE];
		tl_idx    = 4'(row >> (PIX_W * (sx % TILE_SIZE)));
		if (ref_layer[1] && tl_idx != 4'd0)
			return pal_ref[PAL_ENTRIES / 2 + tl_idx];
		if (ref_layer[0] && fb_idx != 4'd0)
			return pal_ref[fb_idx];
		return '0;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic cpu_write(input logic [13:0] a, input logic [31:0] d, input logic [3:0] strb);
		@(posedge clk);
		addr  <= a;
		din   <= d;
		wstrb <= strb;
		@(posedge clk);
		wstrb <= 4'h0;
		@(posedge clk); // ready cycle
	endtask

	task automatic cpu_read_check(input logic [13:0] a, input string name,
			input logic [31:0] expected);
		@(posedge clk);
		addr <= a;
		ren  <= 1'b1;
		@(posedge clk);
		ren <= 1'b0;
		@(posedge clk);
		check_equal(name, expected, dout); // dout as seen in the ready cycle
	endtask

	task automatic run_frame();
		int target;
		target = frames_done + 1;
		@(posedge clk);
		next_field <= 1'b1;
		@(posedge clk);
		next_field <= 1'b0;
		while (frames_done < target)
			@(posedge clk);
		repeat (40) @(posedge clk); // after line 15 the pipeline stays quiet
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %-32s ok", name);
		else
			$display("test %-32s %0d errors", name, errors - errs_before);
	endtask

	// ready follows every access by exactly one cycle
	always @(posedge clk) begin
		if (reset) begin
			acc_q <= 1'b0;
		end else begin
			checks++;
			assert (ready == acc_q) else begin
				errors++;
				$display("CHECK FAILED t=%0t ready expected %b got %b", $time, acc_q, ready);
			end
			acc_q <= ren || (wstrb != 4'h0);
		end
	end

	// the fetch unit keeps at most one external read outstanding
	always @(posedge clk) begin
		if (reset) begin
			read_open <= 1'b0;
		end else begin
			if (mem_read) begin
				checks++;
				assert (!read_open) else begin
					errors++;
					$display("mem_read at t=%0t while the previous read is still outstanding",
						$time);
				end
				read_open <= 1'b1;
			end else if (mem_rvalid) begin
				read_open <= 1'b0;
			end
		end
	end

	// line-buffer writes, and the scanout model
	always @(posedge clk) begin : pixel_check
		logic [Y_W-1:0]     w_line;
		logic [X_W-1:0]     w_x;
		logic [Y_W-1:0]     next_scan;
		logic [COLOR_W-1:0] expected;
		if (reset || next_field) begin
			pix_count = 0;
			foreach (written[i])
				written[i] = 1'b0;
			foreach (line_pixels[i])
				line_pixels[i] = 0;
		end else if (vid_wen) begin
			w_line    = vid_addr[LB_ADDR_W-1:X_W];
			w_x       = vid_addr[X_W-1:0];
			next_scan = scan_line + 1'b1;
			expected  = expected_color(w_line, w_x);
			checks++;
			assert (vid_data == expected) else begin
				errors++;
				$display("CHECK FAILED t=%0t vid_data line %0d x %0d expected %h got %h",
					$time, w_line, w_x, expected, vid_data);
			end
			assert (w_line[0] != scan_line[0]) else begin
				errors++;
				$display("line %0d was written at t=%0t while scan_line %0d is on screen",
					w_line, $time, scan_line);
			end
			assert (!written[vid_addr]) else begin
				errors++;
				$display("pixel line %0d x %0d was written twice at t=%0t", w_line, w_x, $time);
			end
			assert (pix_count < FRAME_PIXELS) else begin
				errors++;
				$display("write at t=%0t after the last line and before next_field", $time);
			end
			if (match_saved) begin
				assert (vid_data == saved[vid_addr]) else begin
					errors++;
					$display("CHECK FAILED t=%0t vid_data line %0d x %0d expected %h got %h",
						$time, w_line, w_x, saved[vid_addr], vid_data);
				end
			end
			if (save_frame)
				saved[vid_addr] = vid_data;
			written[vid_addr] = 1'b1;
			line_pixels[w_line]++;
			pix_count++;
			if (pix_count == FRAME_PIXELS)
				frames_done++;
			if (line_pixels[w_line] == LINE_PIXELS && w_line == next_scan)
				scan_line <= w_line; // scanout moves on to the finished line
		end
	end

	initial begin : stimulus
		int errs_before;
		reset      = 1'b1;
		addr       = '0;
		din        = '0;
		wstrb      = 4'h0;
		ren        = 1'b0;
		next_field = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		errs_before = errors;
		cpu_read_check(FB_ADDR_REG, "dout fb_addr", 32'h007E0000);
		cpu_read_check(PITCH_REG, "dout pitch", 32'd32);
		cpu_read_check(LAYER_REG, "dout layer_en", 32'd0);
		cpu_read_check(OFF_REG, "dout tile_off", 32'd0);
		cpu_write(FB_ADDR_REG, 32'hFF00A5C4, 4'hF); // upper byte not stored
		cpu_write(PITCH_REG, 32'hBEEF0044, 4'hF);
		cpu_write(LAYER_REG, 32'hFFFFFFFD, 4'hF);
		cpu_write(OFF_REG, 32'h8015805D, 4'hF);     // x 93, y 21
		cpu_write(FB_ADDR_REG, 32'h00123456, 4'h7); // partial, ignored
		cpu_read_check(FB_ADDR_REG, "dout fb_addr", 32'h0000A5C4);
		cpu_read_check(PITCH_REG, "dout pitch", 32'h00000044);
		cpu_read_check(LAYER_REG, "dout layer_en", 32'h00000001);
		cpu_read_check(OFF_REG, "dout tile_off", 32'h0015005D);
		ref_fb_addr = 24'h00A5C4;
		ref_pitch   = 16'h0044;
		ref_layer   = 2'b01;
		ref_xoff    = 7'd93;
		ref_yoff    = 7'd21;
		report_test("register access", errs_before);

		errs_before = errors;
		for (int i = 0; i < PAL_ENTRIES; i++) begin
			pal_ref[i] = 24'((i + 1) * 32'h00C3A5E7);
			cpu_write(PAL_BASE + 14'(4 * i), {8'h00, pal_ref[i]}, 4'hF);
		end
		for (int i = 0; i < MAP_WORDS; i++) begin
			map_ref[i] = (i + 3) * 32'h9E3779B9 ^ 32'h5A5A0000;
			cpu_write(MAP_BASE + 14'(4 * i), map_ref[i], 4'hF);
		end
		for (int i = 0; i < TILEMEM_WORDS; i++) begin
			tile_ref[i] = (i + 1) * 32'h2545F491;
			cpu_write(TILE_BASE + 14'(4 * i), tile_ref[i], 4'hF);
		end
		for (int i = 0; i < PAL_ENTRIES; i++)
			cpu_read_check(PAL_BASE + 14'(4 * i), $sformatf("dout palette[%0d]", i),
				{8'h00, pal_ref[i]});
		for (int i = 0; i < MAP_WORDS; i++)
			cpu_read_check(MAP_BASE + 14'(4 * i), $sformatf("dout tilemap[%0d]", i), map_ref[i]);
		for (int i = 0; i < TILEMEM_WORDS; i++)
			cpu_read_check(TILE_BASE + 14'(4 * i), $sformatf("dout tilemem[%0d]", i),
				tile_ref[i]);
		report_test("memory access", errs_before);

		// framebuffer layer only, frame kept for the latency rerun
		errs_before = errors;
		save_frame  = 1'b1;
		run_frame();
		save_frame = 1'b0;
		report_test("framebuffer only", errs_before);

		errs_before = errors;
		match_saved = 1'b1;
		run_frame();
		match_saved = 1'b0;
		report_test("random memory latency", errs_before);

		errs_before = errors;
		cpu_write(LAYER_REG, 32'h00000003, 4'hF);
		cpu_write(OFF_REG, 32'h00390064, 4'hF); // x 100, y 57, both wrap
		ref_layer = 2'b11;
		ref_xoff  = 7'd100;
		ref_yoff  = 7'd57;
		run_frame();
		report_test("tile layer with scroll", errs_before);

		errs_before = errors;
		cpu_write(FB_ADDR_REG, 32'h001F3A00, 4'hF);
		cpu_write(PITCH_REG, 32'h00000300, 4'hF);
		ref_fb_addr = 24'h1F3A00;
		ref_pitch   = 16'h0300;
		run_frame();
		report_test("new base and pitch, buffer flow", errs_before);

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial begin : watchdog
		#(RUN_LIMIT_NS);
		$display("watchdog: run did not finish within %0d ns", RUN_LIMIT_NS);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
vid_regs_pkg.sv
vid_geom_pkg.sv
vid_cpu_regs.sv
vid_fb_fetch.sv
vid_line_sequencer.sv
vid_tile_stage.sv
vid_palette_stage.sv
vid_linerenderer.sv
tb_vid_mem_model.sv
tb_vid_linerenderer.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module tb_vid_linerenderer -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
